/* verilog/ex_pkg.sv */
// Shared widths, operator encoding and payload structs for the execute stage.
// Widths are fixed by RV32; changing XLEN alone is not supported.

package ex_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
    typedef logic [XLEN-1:0]          xlen_t;

    // ------------------------------------------------------------------------
    // Operators
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        // Integer ALU
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Branch compares
        EQ,
        NE,
        LTS,
        GES,
        LTU,
        GEU,
        // Jumps
        JAL,
        JALR,
        // CSR access
        CSR_RW,
        CSR_RS,
        CSR_RC,
        // Multiplications
        MUL,
        MULH,
        MULHU
    } fu_op_e;

    // ------------------------------------------------------------------------
    // Payloads
    // ------------------------------------------------------------------------
    // Issued instruction slot
    typedef struct packed {
        fu_op_e    operator;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // Front-end prediction attached to a control-flow instruction
    typedef struct packed {
        logic  taken;
        xlen_t predict_address;
    } branch_predict_t;

    // Resolution sent back to the front end
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t target_address;
        logic  is_taken;
        logic  is_mispredict;
    } bp_resolve_t;

    // Conditional compares only; jumps are not included
    function automatic logic is_branch_op(fu_op_e op);
        return op inside {EQ, NE, LTS, GES, LTU, GEU};
    endfunction

    function automatic logic is_csr_op(fu_op_e op);
        return op inside {CSR_RW, CSR_RS, CSR_RC};
    endfunction

endpackage

/* verilog/alu.sv */
// Single-cycle integer ALU with the branch compare flag.
// Purely combinational; shift amounts use operand_b[4:0] only.
`timescale 1ns/100ps

module alu (
    input  ex_pkg::fu_data_t fu_data_i,
    output ex_pkg::xlen_t    result_o,
    output logic             branch_res_o
);

    import ex_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;

    // Shared compare results for set-less-than and branches
    logic       equal;
    logic       less_signed;
    logic       less_unsigned;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign shamt = op_b[4:0];

    assign equal         = (op_a == op_b);
    assign less_signed   = ($signed(op_a) < $signed(op_b));
    assign less_unsigned = (op_a < op_b);

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operator)
            ADD:  result_o = op_a + op_b;
            SUB:  result_o = op_a - op_b;
            AND:  result_o = op_a & op_b;
            OR:   result_o = op_a | op_b;
            XOR:  result_o = op_a ^ op_b;
            SLL:  result_o = op_a << shamt;
            SRL:  result_o = op_a >> shamt;
            SRA:  result_o = xlen_t'($signed(op_a) >>> shamt);
            SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
            SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            default: begin
                // CSR write data passes straight through
                if (is_csr_op(fu_data_i.operator)) begin
                    result_o = op_a;
                end
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Branch compare
    // ------------------------------------------------------------------------
    always_comb begin
        branch_res_o = 1'b0;
        if (is_branch_op(fu_data_i.operator)) begin
            case (fu_data_i.operator)
                EQ:      branch_res_o = equal;
                NE:      branch_res_o = ~equal;
                LTS:     branch_res_o = less_signed;
                GES:     branch_res_o = ~less_signed;
                LTU:     branch_res_o = less_unsigned;
                GEU:     branch_res_o = ~less_unsigned;
                default: branch_res_o = 1'b0;
            endcase
        end
    end

endmodule

/* verilog/branch_unit.sv */
// Branch target, link address and prediction check, all combinational.
// Compare outcome comes from the ALU; misaligned targets raise no exception.
`timescale 1ns/100ps

module branch_unit (
    input  ex_pkg::fu_data_t        fu_data_i,
    input  ex_pkg::xlen_t           pc_i,
    input  logic                    is_compressed_instr_i,
    input  logic                    branch_valid_i,
    input  logic                    branch_comp_res_i,
    input  ex_pkg::branch_predict_t branch_predict_i,
    output ex_pkg::xlen_t           branch_result_o,
    output ex_pkg::bp_resolve_t     resolved_branch_o,
    output logic                    resolve_branch_o
);

    import ex_pkg::*;

    logic  is_jump;
    logic  is_jalr;
    logic  taken;
    xlen_t target;
    xlen_t link_addr;
    xlen_t base;

    assign is_jalr = (fu_data_i.operator == JALR);
    assign is_jump = (fu_data_i.operator == JAL) | is_jalr;

    // JALR is register relative, everything else is PC relative
    assign base = is_jalr ? fu_data_i.operand_a : pc_i;

    always_comb begin
        target = base + fu_data_i.imm;
        if (is_jalr) begin
            target[0] = 1'b0;
        end
    end

    assign link_addr = is_compressed_instr_i ? (pc_i + xlen_t'(2)) : (pc_i + xlen_t'(4));

    assign taken = is_jump | (is_branch_op(fu_data_i.operator) & branch_comp_res_i);

    // Written back as rd for jumps
    assign branch_result_o = link_addr;

    // ------------------------------------------------------------------------
    // Resolution
    // ------------------------------------------------------------------------
    always_comb begin
        resolved_branch_o.valid          = branch_valid_i;
        resolved_branch_o.pc             = pc_i;
        resolved_branch_o.is_taken       = taken;
        // Fall-through address when not taken
        resolved_branch_o.target_address = taken ? target : link_addr;
        resolved_branch_o.is_mispredict  = 1'b0;
        if (branch_valid_i) begin
            if (taken != branch_predict_i.taken) begin
                resolved_branch_o.is_mispredict = 1'b1;
            end else if (taken && (target != branch_predict_i.predict_address)) begin
                resolved_branch_o.is_mispredict = 1'b1;
            end
        end
    end

    assign resolve_branch_o = branch_valid_i;

endmodule

/* verilog/csr_buffer.sv */
// Single-entry CSR address buffer; blocks further CSR issue until commit.
// Write data is not stored here because the commit stage reapplies operand_a.
`timescale 1ns/100ps

module csr_buffer (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  ex_pkg::fu_data_t                   fu_data_i,
    input  logic                               csr_valid_i,
    input  logic                               csr_commit_i,
    output logic                               csr_ready_o,
    output ex_pkg::xlen_t                      csr_result_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0]   csr_addr_o
);

    import ex_pkg::*;

    logic                     valid_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // Commit frees the entry in the same cycle
    assign csr_ready_o  = ~valid_q | csr_commit_i;
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_addr_o   = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            if (flush_i) begin
                valid_q <= 1'b0;
            end else if (csr_valid_i) begin
                valid_q <= 1'b1;
                addr_q  <= fu_data_i.imm[CSR_ADDR_BITS-1:0];
            end else if (csr_commit_i) begin
                valid_q <= 1'b0;
            end
        end
    end

endmodule

/* verilog/multiplier.sv */
// 32x32 multiplier with one register stage that accepts an operation every cycle.
// MULHSU is not supported.
`timescale 1ns/100ps

module multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  ex_pkg::fu_data_t  fu_data_i,
    output ex_pkg::xlen_t     result_o,
    output logic              mult_valid_o,
    output ex_pkg::trans_id_t mult_trans_id_o
);

    import ex_pkg::*;

    logic                   sign_ext;
    logic signed [XLEN:0]   mul_a;
    logic signed [XLEN:0]   mul_b;
    logic [2*XLEN-1:0]      product;

    logic [2*XLEN-1:0]      product_q;
    logic                   sel_high_q;
    trans_id_t              trans_id_q;
    logic                   valid_q;

    // Only MULH treats operands as signed
    assign sign_ext = (fu_data_i.operator == MULH);
    assign mul_a    = {sign_ext & fu_data_i.operand_a[XLEN-1], fu_data_i.operand_a};
    assign mul_b    = {sign_ext & fu_data_i.operand_b[XLEN-1], fu_data_i.operand_b};
    // Low 64 bits of the signed 33x33 product
    assign product  = mul_a * mul_b;

    // ------------------------------------------------------------------------
    // Result stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        product_q  <= product;
        sel_high_q <= (fu_data_i.operator == MULH) | (fu_data_i.operator == MULHU);
        trans_id_q <= fu_data_i.trans_id;
    end

    assign result_o        = sel_high_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];
    assign mult_valid_o    = valid_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

/* verilog/ex_stage.sv */
// Fixed-latency execute units sharing one issue slot and one write-back port.
// Issuer must leave the cycle after a multiply free of other issues.
`timescale 1ns/100ps

module ex_stage (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  ex_pkg::fu_data_t                   fu_data_i,
    input  ex_pkg::xlen_t                      pc_i,
    input  logic                               is_compressed_instr_i,
    input  logic                               alu_valid_i,
    input  logic                               branch_valid_i,
    input  ex_pkg::branch_predict_t            branch_predict_i,
    input  logic                               csr_valid_i,
    input  logic                               csr_commit_i,
    input  logic                               mult_valid_i,
    output ex_pkg::xlen_t                      flu_result_o,
    output ex_pkg::trans_id_t                  flu_trans_id_o,
    output logic                               flu_valid_o,
    output logic                               flu_ready_o,
    output ex_pkg::bp_resolve_t                resolved_branch_o,
    output logic                               resolve_branch_o,
    output logic [ex_pkg::CSR_ADDR_BITS-1:0]   csr_addr_o
);

    import ex_pkg::*;

    fu_data_t  alu_data;
    fu_data_t  mult_data;

    xlen_t     alu_result;
    logic      alu_branch_res;
    xlen_t     branch_result;
    xlen_t     csr_result;
    logic      csr_ready;
    xlen_t     mult_result;
    logic      mult_valid;
    trans_id_t mult_trans_id;

    // ------------------------------------------------------------------------
    // Input silencing
    // ------------------------------------------------------------------------
    assign alu_data  = (alu_valid_i | branch_valid_i) ? fu_data_i : '0;
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    // ------------------------------------------------------------------------
    // Units
    // ------------------------------------------------------------------------
    alu i_alu (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    // Target adder sees the raw slot and stays off the gating path
    branch_unit i_branch_unit (
        .fu_data_i             (fu_data_i),
        .pc_i                  (pc_i),
        .is_compressed_instr_i (is_compressed_instr_i),
        .branch_valid_i        (branch_valid_i),
        .branch_comp_res_i     (alu_branch_res),
        .branch_predict_i      (branch_predict_i),
        .branch_result_o       (branch_result),
        .resolved_branch_o     (resolved_branch_o),
        .resolve_branch_o      (resolve_branch_o)
    );

    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    multiplier i_multiplier (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (mult_data),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

    // ------------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    always_comb begin
        // Link address by default
        flu_result_o   = branch_result;
        flu_trans_id_o = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

endmodule

/* dv/tb_clk_gen.sv */
// 20 ns clock, reset held low for the first 3 rising edges
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int unsigned RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

/* dv/ex_stage_props.sv */
// Issue rules and resolve consistency checked in every bound ex_stage instance
`timescale 1ns/100ps

module ex_stage_props (
    input logic                clk_i,
    input logic                rst_ni,
    input logic                alu_valid_i,
    input logic                branch_valid_i,
    input logic                csr_valid_i,
    input logic                mult_valid_i,
    input logic                flu_valid_o,
    input logic                flu_ready_o,
    input logic                resolve_branch_o,
    input ex_pkg::bp_resolve_t resolved_branch_o
);

    logic [3:0] valids;

    assign valids = {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i};

    // One unit per issue slot
    single_issue_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flu_valid_o |-> $onehot0(valids))
        else $error("flu_valid_o high with more than one valid input");

    csr_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_ready_o)
        else $error("csr_valid_i raised while flu_ready_o is low");

    resolve_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resolve_branch_o == resolved_branch_o.valid)
        else $error("resolve_branch_o differs from resolved_branch_o.valid");

endmodule

bind ex_stage ex_stage_props i_ex_stage_props (.*);

/* dv/tb_ex_stage.sv */
// Mixed random issue checked each cycle against a reference model.
// No CSR issue while the buffer is busy; only a MUL or an idle cycle follows a MUL.
`timescale 1ns/100ps

module tb_ex_stage;

    import ex_pkg::*;

    localparam int unsigned NUM_CYCLES    = 2000;
    localparam int unsigned RESET_TIMEOUT = 10;

    logic                     clk;
    logic                     rst_n;
    logic                     flush_i;
    fu_data_t                 fu_data_i;
    xlen_t                    pc_i;
    logic                     is_compressed_instr_i;
    logic                     alu_valid_i;
    logic                     branch_valid_i;
    branch_predict_t          branch_predict_i;
    logic                     csr_valid_i;
    logic                     csr_commit_i;
    logic                     mult_valid_i;
    xlen_t                    flu_result_o;
    trans_id_t                flu_trans_id_o;
    logic                     flu_valid_o;
    logic                     flu_ready_o;
    bp_resolve_t              resolved_branch_o;
    logic                     resolve_branch_o;
    logic [CSR_ADDR_BITS-1:0] csr_addr_o;

    integer seed = 32'h3ef4;

    tb_clk_gen i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    ex_stage i_dut (
        .clk_i  (clk),
        .rst_ni (rst_n),
        .*
    );

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic stop_on_error();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_xlen(string name, xlen_t expected, xlen_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic compare_trans_id(string name, trans_id_t expected, trans_id_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic compare_resolve(string name, bp_resolve_t expected, bp_resolve_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic compare_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------------
    function automatic int random_below(int unsigned limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    // Operator drawn from a contiguous run of the enumeration
    function automatic fu_data_t random_item(int first, int count);
        fu_data_t item;
        item.operator  = fu_op_e'(first + random_below(count));
        item.operand_a = $random(seed);
        item.operand_b = (random_below(4) == 0) ? item.operand_a : $random(seed);
        item.imm       = $random(seed);
        item.trans_id  = trans_id_t'(random_below(8));
        return item;
    endfunction

    function automatic xlen_t alu_model(fu_data_t item);
        xlen_t       a;
        xlen_t       b;
        logic [63:0] wide;
        a    = item.operand_a;
        b    = item.operand_b;
        wide = {{XLEN{a[31]}}, a} >> b[4:0];
        case (item.operator)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return wide[31:0];
            SLT:     return xlen_t'((a[31] != b[31]) ? a[31] : (a < b));
            SLTU:    return xlen_t'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic xlen_t link_address(xlen_t pc, logic compressed);
        return compressed ? pc + 32'd2 : pc + 32'd4;
    endfunction

    function automatic xlen_t branch_target(fu_data_t item, xlen_t pc);
        if (item.operator == JALR) begin
            return (item.operand_a + item.imm) & ~xlen_t'(1);
        end
        return pc + item.imm;
    endfunction

    function automatic bp_resolve_t branch_model(fu_data_t item, xlen_t pc, logic compressed,
                                                 branch_predict_t predict);
        bp_resolve_t res;
        xlen_t       a;
        xlen_t       b;
        logic        lt_s;
        logic        taken;
        a    = item.operand_a;
        b    = item.operand_b;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);
        case (item.operator)
            EQ:      taken = (a == b);
            NE:      taken = (a != b);
            LTS:     taken = lt_s;
            GES:     taken = !lt_s;
            LTU:     taken = (a < b);
            GEU:     taken = (a >= b);
            default: taken = 1'b1;
        endcase
        res.valid          = 1'b1;
        res.pc             = pc;
        res.is_taken       = taken;
        res.target_address = taken ? branch_target(item, pc) : link_address(pc, compressed);
        res.is_mispredict  = (taken != predict.taken) ||
                             (taken && (branch_target(item, pc) != predict.predict_address));
        return res;
    endfunction

    function automatic xlen_t mult_model(fu_data_t item);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        p;
        sa = {{XLEN{item.operand_a[31]}}, item.operand_a};
        sb = {{XLEN{item.operand_b[31]}}, item.operand_b};
        if (item.operator == MULHU) begin
            p = {32'b0, item.operand_a} * {32'b0, item.operand_b};
        end else begin
            p = sa * sb;
        end
        return (item.operator == MUL) ? p[31:0] : p[63:32];
    endfunction

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        fu_data_t                 item;
        xlen_t                    pc;
        logic                     compressed;
        branch_predict_t          predict;
        logic                     commit;
        logic                     kill;
        int                       kind;
        int                       cycles;
        xlen_t                    expected;
        logic                     csr_busy;
        logic [CSR_ADDR_BITS-1:0] csr_addr_model;
        logic                     mult_pend;
        xlen_t                    mult_result;
        trans_id_t                mult_id;
        logic                     after_mult;

        flush_i               <= 1'b0;
        fu_data_i             <= '0;
        pc_i                  <= '0;
        is_compressed_instr_i <= 1'b0;
        alu_valid_i           <= 1'b0;
        branch_valid_i        <= 1'b0;
        branch_predict_i      <= '0;
        csr_valid_i           <= 1'b0;
        csr_commit_i          <= 1'b0;
        mult_valid_i          <= 1'b0;

        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
                stop_on_error();
            end
        end

        @(negedge clk);
        compare_bit("flu_valid_o", 1'b0, flu_valid_o);
        compare_bit("resolve_branch_o", 1'b0, resolve_branch_o);
        compare_bit("flu_ready_o", 1'b1, flu_ready_o);
        compare_xlen("csr_addr_o", '0, xlen_t'(csr_addr_o));

        csr_busy       = 1'b0;
        csr_addr_model = '0;
        mult_pend      = 1'b0;
        mult_result    = '0;
        mult_id        = '0;
        after_mult     = 1'b0;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            // 0 idle, 1 ALU, 2 branch, 3 CSR, 4 multiply
            kind = random_below(5);
            if (after_mult && (kind >= 1) && (kind <= 3)) begin
                kind = 4 * random_below(2);
            end
            if ((csr_busy && (kind == 3)) || (i == NUM_CYCLES - 1)) begin
                kind = 0;
            end
            case (kind)
                1:       item = random_item(int'(ADD), 10);
                2:       item = random_item(int'(EQ), 8);
                3:       item = random_item(int'(CSR_RW), 3);
                4:       item = random_item(int'(MUL), 3);
                default: item = random_item(int'(ADD), 24);
            endcase
            pc                      = $random(seed);
            compressed              = (random_below(2) == 1);
            predict.taken           = (random_below(2) == 1);
            predict.predict_address = (random_below(2) == 1) ? branch_target(item, pc)
                                                             : $random(seed);
            commit = csr_busy && (random_below(4) == 0);
            kill   = (random_below(24) == 0);

            fu_data_i             <= item;
            pc_i                  <= pc;
            is_compressed_instr_i <= compressed;
            branch_predict_i      <= predict;
            alu_valid_i           <= (kind == 1);
            branch_valid_i        <= (kind == 2);
            csr_valid_i           <= (kind == 3);
            mult_valid_i          <= (kind == 4);
            csr_commit_i          <= commit;
            flush_i               <= kill;

            @(negedge clk);
            compare_bit("flu_valid_o", ((kind >= 1) && (kind <= 3)) || mult_pend, flu_valid_o);
            compare_bit("flu_ready_o", !csr_busy || commit, flu_ready_o);
            compare_xlen("csr_addr_o", xlen_t'(csr_addr_model), xlen_t'(csr_addr_o));
            compare_bit("resolve_branch_o", kind == 2, resolve_branch_o);
            if (mult_pend) begin
                compare_xlen("flu_result_o", mult_result, flu_result_o);
                compare_trans_id("flu_trans_id_o", mult_id, flu_trans_id_o);
            end else if ((kind >= 1) && (kind <= 3)) begin
                case (kind)
                    1:       expected = alu_model(item);
                    2:       expected = link_address(pc, compressed);
                    default: expected = item.operand_a;
                endcase
                compare_xlen("flu_result_o", expected, flu_result_o);
                compare_trans_id("flu_trans_id_o", item.trans_id, flu_trans_id_o);
            end
            if (kind == 2) begin
                compare_resolve("resolved_branch_o",
                                branch_model(item, pc, compressed, predict), resolved_branch_o);
            end

            // Flush wins over a new CSR, which wins over commit
            if (kill) begin
                csr_busy = 1'b0;
            end else if (kind == 3) begin
                csr_busy       = 1'b1;
                csr_addr_model = item.imm[CSR_ADDR_BITS-1:0];
            end else if (commit) begin
                csr_busy = 1'b0;
            end
            mult_pend   = (kind == 4) && !kill;
            mult_result = mult_model(item);
            mult_id     = item.trans_id;
            after_mult  = (kind == 4);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* ex_stage.f */
verilog/ex_pkg.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/csr_buffer.sv
verilog/multiplier.sv
verilog/ex_stage.sv
dv/tb_clk_gen.sv
dv/ex_stage_props.sv
dv/tb_ex_stage.sv
